/* wb_subsys.f */
src/rv_isa_pkg.sv
src/wb_pipe_pkg.sv
src/hpm_counter.sv
src/csr_file.sv
src/csr_decode_stage.sv
src/writeback_stage.sv
src/wb_subsys.sv
sim/tb_wb_subsys.sv

/* run_sim.sh */
#!/bin/sh
# build the write-back subsystem testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --top-module tb_wb_subsys \
    -f wb_subsys.f -Mdir "$obj_dir" -o tb_wb_subsys
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"$obj_dir/tb_wb_subsys" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

/* sim/tb_wb_subsys.sv */
// ================================================
// self-checking testbench for the write-back subsystem
// with a CSR reference model and a result monitor
// ================================================

`timescale 1ns/1ps

module tb_wb_subsys;

    localparam int xlen = 32;
    localparam int n_alu = 200;
    localparam int n_scratch = 400;
    // at most three cycles per random instruction plus the directed tests, doubled
    localparam int timeout_cycles = 2 * (3 * (n_alu + n_scratch) + 200);

    typedef struct packed {
        logic [31:0] cyc;
        logic [4:0]  sel;
        logic [31:0] data;
    } wr_exp_t;

    logic            clk;
    logic            reset;
    logic            exec_vld;
    logic [31:0]     exec_insn;
    logic [xlen-1:0] exec_result;
    logic            regwr_en;
    logic [4:0]      regwr_sel;
    logic [xlen-1:0] regwr_data;
    logic            illegal_csr;

    integer seed;
    int     cycle_cnt = 0;
    int     run_edges = 0;
    int     error_count = 0;

    // expected register writes and illegal pulses, keyed by stage 2 edge
    wr_exp_t wr_q[$];
    int      ill_q[$];

    // reference state of the CSRs
    logic [31:0] m_mscratch = '0;
    logic [63:0] m_mcycle = '0;
    int          m_mcycle_edge = 0;
    logic [63:0] m_minstret = '0;

    wb_subsys #(
        .xlen        (xlen)
    ) dut (
        .clk         (clk),
        .reset       (reset),
        .exec_vld    (exec_vld),
        .exec_insn   (exec_insn),
        .exec_result (exec_result),
        .regwr_en    (regwr_en),
        .regwr_sel   (regwr_sel),
        .regwr_data  (regwr_data),
        .illegal_csr (illegal_csr)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // run_edges mirrors the number of edges mcycle has seen
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (!reset) begin
            run_edges = run_edges + 1;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            error_count = error_count + 1;
        end
    endtask

    task automatic end_run();
        $display("tb_wb_subsys finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    function automatic int rand_below(input int n);
        return int'(next_random() % 32'(n));
    endfunction

    // one counter edge with an optional write to either half
    function automatic logic [63:0] step_counter(input logic [63:0] count, input logic wr_low,
                                                 input logic wr_high, input logic [31:0] value);
        if (wr_low) begin
            return {count[63:32], value};
        end
        if (wr_high) begin
            return {value, count[31:0] + 32'd1};
        end
        return count + 64'd1;
    endfunction

    function automatic void predict_wb(input logic [31:0] insn, input logic [31:0] operand,
                                       input int s2_edge, output logic [31:0] rd_value,
                                       output logic illegal);
        logic [2:0]  f3;
        logic [11:0] addr;
        logic        wr;
        logic [31:0] old_value;
        logic [31:0] new_value;

        f3 = insn[rv_isa_pkg::funct3_msb_c:rv_isa_pkg::funct3_lsb_c];
        addr = insn[rv_isa_pkg::csr_msb_c:rv_isa_pkg::csr_lsb_c];
        illegal = 1'b0;
        wr = 1'b0;
        old_value = '0;
        new_value = '0;
        rd_value = operand;
        // mcycle as it stands just before the stage 2 edge
        m_mcycle = m_mcycle + 64'(s2_edge - 1 - m_mcycle_edge);
        m_mcycle_edge = s2_edge;
        if (insn[6:0] == rv_isa_pkg::opcode_system_c && f3[1:0] != 2'b00) begin
            case (addr)
                rv_isa_pkg::csr_mscratch_c:  old_value = m_mscratch;
                rv_isa_pkg::csr_mcycle_c:    old_value = m_mcycle[31:0];
                rv_isa_pkg::csr_mcycleh_c:   old_value = m_mcycle[63:32];
                rv_isa_pkg::csr_minstret_c:  old_value = m_minstret[31:0];
                rv_isa_pkg::csr_minstreth_c: old_value = m_minstret[63:32];
                default:                     illegal = 1'b1;
            endcase
            case (f3[1:0])
                2'b10:   new_value = old_value | operand;
                2'b11:   new_value = old_value & ~operand;
                default: new_value = operand;
            endcase
            // set and clear with a zero rs1 or zimm field only read
            wr = !illegal && (f3[1:0] == 2'b01 || insn[19:15] != 5'd0);
            rd_value = old_value;
        end
        if (wr && addr == rv_isa_pkg::csr_mscratch_c) begin
            m_mscratch = new_value;
        end
        m_mcycle = step_counter(m_mcycle, wr && addr == rv_isa_pkg::csr_mcycle_c,
                                wr && addr == rv_isa_pkg::csr_mcycleh_c, new_value);
        m_minstret = step_counter(m_minstret, wr && addr == rv_isa_pkg::csr_minstret_c,
                                  wr && addr == rv_isa_pkg::csr_minstreth_c, new_value);
    endfunction

    task automatic issue(input logic [31:0] insn, input logic [31:0] operand);
        logic [31:0] rd_value;
        logic        illegal;
        wr_exp_t     exp;

        @(posedge clk);
        #1;
        exec_vld = 1'b1;
        exec_insn = insn;
        exec_result = operand;
        predict_wb(insn, operand, run_edges + 2, rd_value, illegal);
        exp.cyc = 32'(run_edges + 2);
        exp.sel = insn[rv_isa_pkg::rd_msb_c:rv_isa_pkg::rd_lsb_c];
        exp.data = rd_value;
        if (illegal) begin
            ill_q.push_back(run_edges + 2);
        end else if (exp.sel != 5'd0) begin
            wr_q.push_back(exp);
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            exec_vld = 1'b0;
        end
    endtask

    task automatic alu_op(input logic [4:0] rd);
        logic [31:0] r;

        r = next_random();
        issue({r[31:12], rd, 7'b0110011}, next_random());
    endtask

    task automatic csr_op(input logic [2:0] f3, input logic [11:0] addr, input logic [4:0] rs1,
                          input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] operand;

        // immediate forms carry zimm, x0 reads as zero
        if (f3[2]) begin
            operand = {27'd0, rs1};
        end else begin
            operand = (rs1 == 5'd0) ? 32'd0 : value;
        end
        issue({addr, rs1, f3, rd, rv_isa_pkg::opcode_system_c}, operand);
    endtask

    initial begin : main
        logic [31:0] r;
        logic [2:0]  f3;

        seed = 32'h7321b627;
        reset = 1'b1;
        exec_vld = 1'b0;
        exec_insn = '0;
        exec_result = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        // ordinary instructions, every eighth one targets x0
        for (int i = 0; i < n_alu; i++) begin
            r = next_random();
            alu_op((i % 8 == 0) ? 5'd0 : r[4:0]);
            idle(rand_below(3));
        end

        // random mscratch read-modify-writes
        for (int i = 0; i < n_scratch; i++) begin
            r = next_random();
            case (rand_below(6))
                0:       f3 = rv_isa_pkg::csrrw;
                1:       f3 = rv_isa_pkg::csrrs;
                2:       f3 = rv_isa_pkg::csrrc;
                3:       f3 = rv_isa_pkg::csrrwi;
                4:       f3 = rv_isa_pkg::csrrsi;
                default: f3 = rv_isa_pkg::csrrci;
            endcase
            csr_op(f3, rv_isa_pkg::csr_mscratch_c, (r[1:0] == 2'b00) ? 5'd0 : r[6:2],
                   r[11:7], next_random());
            idle(rand_below(3));
        end

        // ================================================
        // counters
        // ================================================
        csr_op(rv_isa_pkg::csrrs, rv_isa_pkg::csr_mcycle_c, 5'd0, 5'd3, '0);
        csr_op(rv_isa_pkg::csrrs, rv_isa_pkg::csr_mcycleh_c, 5'd0, 5'd4, '0);
        // all ones in the low half carries into mcycleh one edge later
        csr_op(rv_isa_pkg::csrrw, rv_isa_pkg::csr_mcycle_c, 5'd9, 5'd5, 32'hffff_ffff);
        csr_op(rv_isa_pkg::csrrs, rv_isa_pkg::csr_mcycle_c, 5'd0, 5'd6, '0);
        csr_op(rv_isa_pkg::csrrs, rv_isa_pkg::csr_mcycleh_c, 5'd0, 5'd7, '0);
        idle(2);
        csr_op(rv_isa_pkg::csrrs, rv_isa_pkg::csr_mcycleh_c, 5'd0, 5'd8, '0);
        csr_op(rv_isa_pkg::csrrwi, rv_isa_pkg::csr_mcycleh_c, 5'd21, 5'd9, '0);
        csr_op(rv_isa_pkg::csrrs, rv_isa_pkg::csr_mcycleh_c, 5'd0, 5'd10, '0);
        csr_op(rv_isa_pkg::csrrs, rv_isa_pkg::csr_minstret_c, 5'd0, 5'd11, '0);
        csr_op(rv_isa_pkg::csrrs, rv_isa_pkg::csr_minstreth_c, 5'd0, 5'd12, '0);
        csr_op(rv_isa_pkg::csrrw, rv_isa_pkg::csr_minstret_c, 5'd12, 5'd13, 32'h0000_1000);
        for (int i = 0; i < 4; i++) begin
            alu_op(5'd14);
            idle(i % 2);
        end
        csr_op(rv_isa_pkg::csrrs, rv_isa_pkg::csr_minstret_c, 5'd0, 5'd15, '0);
        csr_op(rv_isa_pkg::csrrw, rv_isa_pkg::csr_minstret_c, 5'd12, 5'd16, 32'hffff_fffe);
        csr_op(rv_isa_pkg::csrrs, rv_isa_pkg::csr_minstreth_c, 5'd0, 5'd17, '0);
        csr_op(rv_isa_pkg::csrrs, rv_isa_pkg::csr_minstreth_c, 5'd0, 5'd18, '0);
        csr_op(rv_isa_pkg::csrrw, rv_isa_pkg::csr_minstreth_c, 5'd12, 5'd19, 32'h0000_0042);
        csr_op(rv_isa_pkg::csrrs, rv_isa_pkg::csr_minstreth_c, 5'd0, 5'd20, '0);
        csr_op(rv_isa_pkg::csrrs, rv_isa_pkg::csr_minstret_c, 5'd0, 5'd21, '0);

        // unknown addresses, each followed by an mscratch read
        for (int i = 0; i < 6; i++) begin
            f3 = (i % 2 == 0) ? rv_isa_pkg::csrrw : rv_isa_pkg::csrrsi;
            r = (i % 3 == 0) ? 32'h305 : ((i % 3 == 1) ? 32'hc00 : 32'h7c0);
            csr_op(f3, r[11:0], 5'd1, 5'd22, next_random());
            csr_op(rv_isa_pkg::csrrs, rv_isa_pkg::csr_mscratch_c, 5'd0, 5'd23, '0);
            idle(i % 2);
        end
        idle(1);

        while (wr_q.size() != 0 || ill_q.size() != 0) begin
            @(negedge clk);
        end
        idle(3);
        end_run();
    end

    // compares outputs in mid cycle, away from the driving edge
    always @(negedge clk) begin : monitor
        wr_exp_t exp;

        if (!reset) begin
            if (wr_q.size() != 0 && int'(wr_q[0].cyc) < run_edges) begin
                $display("ERROR: expected register write to x%0d did not happen", wr_q[0].sel);
                error_count = error_count + 1;
                wr_q.delete(0);
            end
            if (ill_q.size() != 0 && ill_q[0] - 1 < run_edges) begin
                $display("ERROR: expected illegal_csr pulse did not happen");
                error_count = error_count + 1;
                ill_q.delete(0);
            end
            if (illegal_csr) begin
                if (ill_q.size() == 0) begin
                    $display("ERROR: illegal_csr pulsed for a legal instruction");
                    error_count = error_count + 1;
                end else begin
                    check_value("illegal_csr cycle", 32'(ill_q.pop_front() - 1), 32'(run_edges));
                end
            end
            if (regwr_en) begin
                if (wr_q.size() == 0) begin
                    $display("ERROR: regwr_en pulsed with no register write expected");
                    error_count = error_count + 1;
                end else begin
                    exp = wr_q.pop_front();
                    check_value("regwr_en cycle", exp.cyc, 32'(run_edges));
                    check_value("regwr_sel", {27'd0, exp.sel}, {27'd0, regwr_sel});
                    check_value("regwr_data", exp.data, regwr_data);
                end
            end
        end
    end

    initial begin : watchdog
        wait (cycle_cnt >= timeout_cycles);
        $display("ERROR: timeout after %0d cycles", cycle_cnt);
        error_count = error_count + 1;
        end_run();
    end

endmodule

/* src/wb_subsys.sv */
// ================================================
// write-back subsystem top with decode, write-back
// and machine CSR file
// ================================================

`timescale 1ns/1ps

module wb_subsys #(
    parameter int xlen = 32
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            exec_vld,
    input  logic [31:0]     exec_insn,
    input  logic [xlen-1:0] exec_result,
    output logic            regwr_en,
    output logic [4:0]      regwr_sel,
    output logic [xlen-1:0] regwr_data,
    output logic            illegal_csr
);

    // stage 1 to stage 2
    logic                  dec_vld;
    logic                  dec_is_csr;
    wb_pipe_pkg::csr_op_e  dec_op;
    wb_pipe_pkg::csr_sel_e dec_sel;
    logic [4:0]            dec_rd;
    logic [xlen-1:0]       dec_operand;
    logic                  dec_wr_suppress;

    // stage 2 to CSR file
    wb_pipe_pkg::csr_sel_e csr_sel;
    logic [xlen-1:0]       csr_rdata;
    logic                  csr_wr_en;
    logic [xlen-1:0]       csr_wdata;
    logic                  retire;

    csr_decode_stage #(
        .xlen            (xlen)
    ) u_decode (
        .clk             (clk),
        .reset           (reset),
        .exec_vld        (exec_vld),
        .exec_insn       (exec_insn),
        .exec_result     (exec_result),
        .dec_vld         (dec_vld),
        .dec_is_csr      (dec_is_csr),
        .dec_op          (dec_op),
        .dec_sel         (dec_sel),
        .dec_rd          (dec_rd),
        .dec_operand     (dec_operand),
        .dec_wr_suppress (dec_wr_suppress)
    );

    writeback_stage #(
        .xlen            (xlen)
    ) u_wb (
        .clk             (clk),
        .reset           (reset),
        .dec_vld         (dec_vld),
        .dec_is_csr      (dec_is_csr),
        .dec_op          (dec_op),
        .dec_sel         (dec_sel),
        .dec_rd          (dec_rd),
        .dec_operand     (dec_operand),
        .dec_wr_suppress (dec_wr_suppress),
        .csr_rdata       (csr_rdata),
        .csr_sel         (csr_sel),
        .csr_wr_en       (csr_wr_en),
        .csr_wdata       (csr_wdata),
        .retire          (retire),
        .regwr_en        (regwr_en),
        .regwr_sel       (regwr_sel),
        .regwr_data      (regwr_data),
        .illegal_csr     (illegal_csr)
    );

    csr_file #(
        .xlen            (xlen)
    ) u_csr (
        .clk             (clk),
        .reset           (reset),
        .csr_sel         (csr_sel),
        .csr_wr_en       (csr_wr_en),
        .csr_wdata       (csr_wdata),
        .retire          (retire),
        .csr_rdata       (csr_rdata)
    );

endmodule

/* src/writeback_stage.sv */
// ================================================
// stage 2 performs the CSR read-modify-write and
// registers the integer register file write
// ================================================

`timescale 1ns/1ps

module writeback_stage #(
    parameter int xlen = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  dec_vld,
    input  logic                  dec_is_csr,
    input  wb_pipe_pkg::csr_op_e  dec_op,
    input  wb_pipe_pkg::csr_sel_e dec_sel,
    input  logic [4:0]            dec_rd,
    input  logic [xlen-1:0]       dec_operand,
    input  logic                  dec_wr_suppress,
    input  logic [xlen-1:0]       csr_rdata,
    output wb_pipe_pkg::csr_sel_e csr_sel,
    output logic                  csr_wr_en,
    output logic [xlen-1:0]       csr_wdata,
    output logic                  retire,
    output logic                  regwr_en,
    output logic [4:0]            regwr_sel,
    output logic [xlen-1:0]       regwr_data,
    output logic                  illegal_csr
);

    logic csr_known;

    assign csr_sel   = dec_sel;
    assign csr_known = (dec_sel != wb_pipe_pkg::sel_none);

    always_comb begin
        case (dec_op)
            wb_pipe_pkg::op_set:   csr_wdata = csr_rdata | dec_operand;
            wb_pipe_pkg::op_clear: csr_wdata = csr_rdata & ~dec_operand;
            default:               csr_wdata = dec_operand;
        endcase
    end

    // write, retire and illegal all land on the stage 2 edge
    assign csr_wr_en   = dec_vld && dec_is_csr && csr_known && !dec_wr_suppress;
    assign illegal_csr = dec_vld && dec_is_csr && !csr_known;
    assign retire      = dec_vld;

    always_ff @(posedge clk) begin
        if (reset) begin
            regwr_en <= 1'b0;
        end else begin
            regwr_en <= dec_vld && !illegal_csr && (dec_rd != 5'd0);
        end
    end

    // rd gets the CSR value from before this instruction's write
    always_ff @(posedge clk) begin
        if (dec_vld) begin
            regwr_sel  <= dec_rd;
            regwr_data <= dec_is_csr ? csr_rdata : dec_operand;
        end
    end

    a_illegal_no_write : assert property (
        @(posedge clk) disable iff (reset) !(illegal_csr && csr_wr_en)
    );

    a_no_x0_write : assert property (
        @(posedge clk) disable iff (reset) regwr_en |-> (regwr_sel != 5'd0)
    );

endmodule

/* src/csr_decode_stage.sv */
// ================================================
// stage 1 registers the execute packet and decodes
// the CSR operation, target and write suppression
// ================================================

`timescale 1ns/1ps

module csr_decode_stage #(
    parameter int xlen = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  exec_vld,
    input  logic [31:0]           exec_insn,
    input  logic [xlen-1:0]       exec_result,
    output logic                  dec_vld,
    output logic                  dec_is_csr,
    output wb_pipe_pkg::csr_op_e  dec_op,
    output wb_pipe_pkg::csr_sel_e dec_sel,
    output logic [4:0]            dec_rd,
    output logic [xlen-1:0]       dec_operand,
    output logic                  dec_wr_suppress
);

    logic [6:0]               opcode;
    logic [2:0]               funct3;
    logic [4:0]               rs1;
    logic [11:0]              csr_addr;
    logic                     is_csr;
    wb_pipe_pkg::csr_op_e     op;
    wb_pipe_pkg::csr_sel_e    sel;

    assign opcode   = exec_insn[rv_isa_pkg::opcode_msb_c:rv_isa_pkg::opcode_lsb_c];
    assign funct3   = exec_insn[rv_isa_pkg::funct3_msb_c:rv_isa_pkg::funct3_lsb_c];
    assign rs1      = exec_insn[rv_isa_pkg::rs1_msb_c:rv_isa_pkg::rs1_lsb_c];
    assign csr_addr = exec_insn[rv_isa_pkg::csr_msb_c:rv_isa_pkg::csr_lsb_c];

    // funct3 of 000 and 100 are not CSR accesses
    assign is_csr = (opcode == rv_isa_pkg::opcode_system_c) && (funct3[1:0] != 2'b00);

    always_comb begin
        case (rv_isa_pkg::csr_funct3_e'(funct3))
            rv_isa_pkg::csrrs, rv_isa_pkg::csrrsi: op = wb_pipe_pkg::op_set;
            rv_isa_pkg::csrrc, rv_isa_pkg::csrrci: op = wb_pipe_pkg::op_clear;
            default:                               op = wb_pipe_pkg::op_rw;
        endcase
    end

    always_comb begin
        case (csr_addr)
            rv_isa_pkg::csr_mscratch_c:  sel = wb_pipe_pkg::sel_mscratch;
            rv_isa_pkg::csr_mcycle_c:    sel = wb_pipe_pkg::sel_mcycle;
            rv_isa_pkg::csr_mcycleh_c:   sel = wb_pipe_pkg::sel_mcycleh;
            rv_isa_pkg::csr_minstret_c:  sel = wb_pipe_pkg::sel_minstret;
            rv_isa_pkg::csr_minstreth_c: sel = wb_pipe_pkg::sel_minstreth;
            default:                     sel = wb_pipe_pkg::sel_none;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_vld <= 1'b0;
        end else begin
            dec_vld <= exec_vld;
        end
    end

    // payload only loads on a valid strobe
    always_ff @(posedge clk) begin
        if (exec_vld) begin
            dec_is_csr      <= is_csr;
            dec_op          <= op;
            dec_sel         <= sel;
            dec_rd          <= exec_insn[rv_isa_pkg::rd_msb_c:rv_isa_pkg::rd_lsb_c];
            dec_operand     <= exec_result;
            // set and clear with x0 or zimm 0 only read
            dec_wr_suppress <= (op != wb_pipe_pkg::op_rw) && (rs1 == 5'd0);
        end
    end

    a_vld_from_strobe : assert property (
        @(posedge clk) disable iff (reset) (dec_vld && $past(dec_vld)) |-> $past(exec_vld)
    );

endmodule

/* src/csr_file.sv */
// ================================================
// machine CSRs mscratch, mcycle and minstret with a
// combinational read port and a single write port
// ================================================

`timescale 1ns/1ps

module csr_file #(
    parameter int xlen = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  wb_pipe_pkg::csr_sel_e csr_sel,
    input  logic                  csr_wr_en,
    input  logic [xlen-1:0]       csr_wdata,
    input  logic                  retire,
    output logic [xlen-1:0]       csr_rdata
);

    logic [xlen-1:0]   mscratch;
    logic [2*xlen-1:0] mcycle;
    logic [2*xlen-1:0] minstret;

    logic wr_mscratch;
    logic wr_mcycle;
    logic wr_mcycleh;
    logic wr_minstret;
    logic wr_minstreth;

    // ================================================
    // write routing
    // ================================================

    assign wr_mscratch  = csr_wr_en && (csr_sel == wb_pipe_pkg::sel_mscratch);
    assign wr_mcycle    = csr_wr_en && (csr_sel == wb_pipe_pkg::sel_mcycle);
    assign wr_mcycleh   = csr_wr_en && (csr_sel == wb_pipe_pkg::sel_mcycleh);
    assign wr_minstret  = csr_wr_en && (csr_sel == wb_pipe_pkg::sel_minstret);
    assign wr_minstreth = csr_wr_en && (csr_sel == wb_pipe_pkg::sel_minstreth);

    always_ff @(posedge clk) begin
        if (reset) begin
            mscratch <= '0;
        end else if (wr_mscratch) begin
            mscratch <= csr_wdata;
        end
    end

    // free running cycle counter
    hpm_counter #(
        .xlen    (xlen)
    ) u_mcycle (
        .clk     (clk),
        .reset   (reset),
        .incr    (1'b1),
        .wr_low  (wr_mcycle),
        .wr_high (wr_mcycleh),
        .wdata   (csr_wdata),
        .count   (mcycle)
    );

    // counts every instruction leaving the write-back stage
    hpm_counter #(
        .xlen    (xlen)
    ) u_minstret (
        .clk     (clk),
        .reset   (reset),
        .incr    (retire),
        .wr_low  (wr_minstret),
        .wr_high (wr_minstreth),
        .wdata   (csr_wdata),
        .count   (minstret)
    );

    // ================================================
    // read mux
    // ================================================

    always_comb begin
        case (csr_sel)
            wb_pipe_pkg::sel_mscratch:  csr_rdata = mscratch;
            wb_pipe_pkg::sel_mcycle:    csr_rdata = mcycle[xlen-1:0];
            wb_pipe_pkg::sel_mcycleh:   csr_rdata = mcycle[2*xlen-1:xlen];
            wb_pipe_pkg::sel_minstret:  csr_rdata = minstret[xlen-1:0];
            wb_pipe_pkg::sel_minstreth: csr_rdata = minstret[2*xlen-1:xlen];
            default:                    csr_rdata = '0;
        endcase
    end

endmodule

/* src/hpm_counter.sv */
// ================================================
// 64-bit event counter built from two xlen halves,
// each half writable on its own
// ================================================

`timescale 1ns/1ps

module hpm_counter #(
    parameter int xlen = 32
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                incr,
    input  logic                wr_low,
    input  logic                wr_high,
    input  logic [xlen-1:0]     wdata,
    output logic [2*xlen-1:0]   count
);

    logic [xlen-1:0] count_low;
    logic [xlen-1:0] count_high;
    logic            carry;

    // low half about to roll over
    assign carry = incr && (count_low == {xlen{1'b1}});

    always_ff @(posedge clk) begin
        if (reset) begin
            count_low  <= '0;
            count_high <= '0;
        end else begin
            if (wr_low) begin
                count_low <= wdata;
            end else if (incr) begin
                count_low <= count_low + xlen'(1);
            end

            // a low write replaces the value that would have carried
            if (wr_high) begin
                count_high <= wdata;
            end else if (carry && !wr_low) begin
                count_high <= count_high + xlen'(1);
            end
        end
    end

    assign count = {count_high, count_low};

    // the CSR file only ever targets one half per instruction
    a_single_half_wr : assert property (
        @(posedge clk) disable iff (reset) !(wr_low && wr_high)
    );

endmodule

/* src/wb_pipe_pkg.sv */
// ================================================
// internal encodings passed between the decode and
// write-back stages and the CSR file
// ================================================

package wb_pipe_pkg;

    // low funct3 bits line up with the operation
    typedef enum logic [1:0] {
        op_rw    = 2'b01,
        op_set   = 2'b10,
        op_clear = 2'b11
    } csr_op_e;

    // sel_none marks an address outside the implemented set
    typedef enum logic [2:0] {
        sel_none      = 3'd0,
        sel_mscratch  = 3'd1,
        sel_mcycle    = 3'd2,
        sel_mcycleh   = 3'd3,
        sel_minstret  = 3'd4,
        sel_minstreth = 3'd5
    } csr_sel_e;

endpackage

/* src/rv_isa_pkg.sv */
// ================================================
// RV32 instruction set definitions shared by the
// write-back pipeline and its testbench
// ================================================

package rv_isa_pkg;

    // major opcode for CSR access and environment calls
    localparam logic [6:0] opcode_system_c = 7'b1110011;

    typedef enum logic [2:0] {
        csrrw  = 3'b001,
        csrrs  = 3'b010,
        csrrc  = 3'b011,
        csrrwi = 3'b101,
        csrrsi = 3'b110,
        csrrci = 3'b111
    } csr_funct3_e;

    // machine level CSR addresses
    localparam logic [11:0] csr_mscratch_c  = 12'h340;
    localparam logic [11:0] csr_mcycle_c    = 12'hB00;
    localparam logic [11:0] csr_minstret_c  = 12'hB02;
    localparam logic [11:0] csr_mcycleh_c   = 12'hB80;
    localparam logic [11:0] csr_minstreth_c = 12'hB82;

    // instruction field positions
    localparam int opcode_lsb_c = 0;
    localparam int opcode_msb_c = 6;
    localparam int rd_lsb_c     = 7;
    localparam int rd_msb_c     = 11;
    localparam int funct3_lsb_c = 12;
    localparam int funct3_msb_c = 14;
    localparam int rs1_lsb_c    = 15;
    localparam int rs1_msb_c    = 19;
    localparam int csr_lsb_c    = 20;
    localparam int csr_msb_c    = 31;

endpackage
